// File: rtl/rv_core_params.svh
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

// Data path and PC width
`define XLEN 32

// Integer register file
`define NUM_REGS   32
`define REG_ADDR_W 5

`endif

// File: rtl/rv_core_pkg.sv
`include "rv_core_params.svh"

package rv_core_pkg;

	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011
	} opcode_e;

	typedef enum logic [4:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_JAL, BR_JALR
	} br_sel_e;

	typedef enum logic [1:0] {
		WB_ALU, WB_MEM, WB_PC4
	} wb_sel_e;

	// One instruction word seen through each of the six RV32I formats
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			opcode_e    opcode;
		} r_fmt;
		struct packed {
			logic [11:0] imm_11_0;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			opcode_e     opcode;
		} i_fmt;
		struct packed {
			logic [6:0] imm_11_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_4_0;
			opcode_e    opcode;
		} s_fmt;
		struct packed {
			logic       imm_12;
			logic [5:0] imm_10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm_4_1;
			logic       imm_11;
			opcode_e    opcode;
		} b_fmt;
		struct packed {
			logic [19:0] imm_31_12;
			logic [4:0]  rd;
			opcode_e     opcode;
		} u_fmt;
		struct packed {
			logic       imm_20;
			logic [9:0] imm_10_1;
			logic       imm_11;
			logic [7:0] imm_19_12;
			logic [4:0] rd;
			opcode_e    opcode;
		} j_fmt;
	} instr_u;

	typedef struct packed {
		br_sel_e    br_sel;
		logic       br_un;
		logic       opa_sel;   // PC in place of rs1
		logic       opb_sel;   // Immediate in place of rs2
		alu_op_e    alu_op;
		logic       rd_wren;
		logic       mem_wren;
		wb_sel_e    wb_sel;
		logic [2:0] sl_sel;    // funct3 size code of loads and stores
		logic       insn_vld;
	} ctrl_t;

	typedef struct packed {
		logic [`XLEN-1:0]       pc;
		logic [`REG_ADDR_W-1:0] rs1_addr;
		logic [`REG_ADDR_W-1:0] rs2_addr;
		logic [`REG_ADDR_W-1:0] rd_addr;
		ctrl_t                  ctrl;
		logic [`XLEN-1:0]       imm;
		logic [`XLEN-1:0]       rs1_data;
		logic [`XLEN-1:0]       rs2_data;
	} id_ex_t;

	typedef struct packed {
		logic                   wren;
		logic [`REG_ADDR_W-1:0] addr;
		logic [`XLEN-1:0]       data;
	} wb_t;

	typedef struct packed {
		logic                   valid;
		logic [`XLEN-1:0]       alu_result;
		logic [`REG_ADDR_W-1:0] rd_addr;
		logic                   rd_wren;
		wb_sel_e                wb_sel;
		logic                   mem_wren;
		logic [2:0]             sl_sel;
		logic [`XLEN-1:0]       store_data;
		logic                   branch_taken;
		logic [`XLEN-1:0]       target_pc;
		logic [`XLEN-1:0]       pc;
	} ex_res_t;

endpackage

// File: rtl/rv_decoder.sv
`timescale 1ns/1ps
`include "rv_core_params.svh"

module rv_decoder import rv_core_pkg::*; (
	input  instr_u                 i_instr,
	input  logic                   i_insn_vld,
	output ctrl_t                  o_ctrl,
	output logic [`XLEN-1:0]       o_imm,
	output logic [`REG_ADDR_W-1:0] o_rs1_addr,
	output logic [`REG_ADDR_W-1:0] o_rs2_addr,
	output logic [`REG_ADDR_W-1:0] o_rd_addr
);

	opcode_e    opcode;
	logic [2:0] funct3;
	logic       alt_bit;   // Instruction bit 30 selects SUB and SRA
	logic       legal;
	alu_op_e    arith_op;
	ctrl_t      ctrl;

	assign opcode  = i_instr.r_fmt.opcode;
	assign funct3  = i_instr.r_fmt.funct3;
	assign alt_bit = i_instr.r_fmt.funct7[5];

	assign o_rs1_addr = i_instr.r_fmt.rs1;
	assign o_rs2_addr = i_instr.r_fmt.rs2;
	assign o_rd_addr  = i_instr.r_fmt.rd;

	// Shared ALU decode for OP and OP_IMM, only OP has SUB
	always_comb begin
		case (funct3)
			3'b000:  arith_op = (opcode == OPC_OP && alt_bit) ? ALU_SUB : ALU_ADD;
			3'b001:  arith_op = ALU_SLL;
			3'b010:  arith_op = ALU_SLT;
			3'b011:  arith_op = ALU_SLTU;
			3'b100:  arith_op = ALU_XOR;
			3'b101:  arith_op = alt_bit ? ALU_SRA : ALU_SRL;
			3'b110:  arith_op = ALU_OR;
			default: arith_op = ALU_AND;
		endcase
	end

	always_comb begin
		ctrl          = '0;
		ctrl.br_sel   = BR_NONE;
		ctrl.alu_op   = ALU_ADD;
		ctrl.wb_sel   = WB_ALU;
		ctrl.sl_sel   = funct3;
		ctrl.insn_vld = 1'b1;
		legal         = 1'b1;
		o_imm         = '0;
		case (opcode)
			OPC_LUI: begin
				o_imm        = {i_instr.u_fmt.imm_31_12, 12'b0};
				ctrl.opb_sel = 1'b1;
				ctrl.alu_op  = ALU_PASS_B;
				ctrl.rd_wren = 1'b1;
			end
			OPC_AUIPC: begin
				o_imm        = {i_instr.u_fmt.imm_31_12, 12'b0};
				ctrl.opa_sel = 1'b1;
				ctrl.opb_sel = 1'b1;
				ctrl.rd_wren = 1'b1;
			end
			OPC_JAL: begin
				o_imm = {{(`XLEN-20){i_instr.j_fmt.imm_20}}, i_instr.j_fmt.imm_19_12,
					i_instr.j_fmt.imm_11, i_instr.j_fmt.imm_10_1, 1'b0};
				ctrl.br_sel  = BR_JAL;
				ctrl.rd_wren = 1'b1;
				ctrl.wb_sel  = WB_PC4;   // Link address, target comes from the adder
			end
			OPC_JALR: begin
				o_imm = {{(`XLEN-12){i_instr.i_fmt.imm_11_0[11]}}, i_instr.i_fmt.imm_11_0};
				ctrl.br_sel  = BR_JALR;
				ctrl.rd_wren = 1'b1;
				ctrl.wb_sel  = WB_PC4;
				legal        = (funct3 == 3'b000);
			end
			OPC_BRANCH: begin
				o_imm = {{(`XLEN-12){i_instr.b_fmt.imm_12}}, i_instr.b_fmt.imm_11,
					i_instr.b_fmt.imm_10_5, i_instr.b_fmt.imm_4_1, 1'b0};
				ctrl.br_un = funct3[1];   // BLTU and BGEU
				case (funct3)
					3'b000:         ctrl.br_sel = BR_EQ;
					3'b001:         ctrl.br_sel = BR_NE;
					3'b100, 3'b110: ctrl.br_sel = BR_LT;
					3'b101, 3'b111: ctrl.br_sel = BR_GE;
					default:        legal = 1'b0;
				endcase
			end
			OPC_LOAD: begin
				o_imm = {{(`XLEN-12){i_instr.i_fmt.imm_11_0[11]}}, i_instr.i_fmt.imm_11_0};
				ctrl.opb_sel = 1'b1;
				ctrl.rd_wren = 1'b1;
				ctrl.wb_sel  = WB_MEM;
				legal        = (funct3 != 3'b011) && (funct3[2:1] != 2'b11);
			end
			OPC_STORE: begin
				o_imm = {{(`XLEN-12){i_instr.s_fmt.imm_11_5[6]}}, i_instr.s_fmt.imm_11_5,
					i_instr.s_fmt.imm_4_0};
				ctrl.opb_sel  = 1'b1;
				ctrl.mem_wren = 1'b1;
				legal         = !funct3[2] && (funct3 != 3'b011);
			end
			OPC_OP_IMM: begin
				o_imm = {{(`XLEN-12){i_instr.i_fmt.imm_11_0[11]}}, i_instr.i_fmt.imm_11_0};
				ctrl.opb_sel = 1'b1;
				ctrl.alu_op  = arith_op;
				ctrl.rd_wren = 1'b1;
			end
			OPC_OP: begin
				ctrl.alu_op  = arith_op;
				ctrl.rd_wren = 1'b1;
			end
			default: legal = 1'b0;
		endcase
	end

	// A bubble must not write anything or redirect the PC
	always_comb begin
		o_ctrl = ctrl;
		if (!(i_insn_vld && legal)) begin
			o_ctrl.insn_vld = 1'b0;
			o_ctrl.rd_wren  = 1'b0;
			o_ctrl.mem_wren = 1'b0;
			o_ctrl.br_sel   = BR_NONE;
		end
	end

endmodule

// File: rtl/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_core_params.svh"

module rv_regfile import rv_core_pkg::*; (
	input  logic                   i_clk,
	input  logic                   reset,
	input  wb_t                    i_wb,
	input  logic [`REG_ADDR_W-1:0] i_rs1_addr,
	input  logic [`REG_ADDR_W-1:0] i_rs2_addr,
	output logic [`XLEN-1:0]       o_rs1_data,
	output logic [`XLEN-1:0]       o_rs2_data
);

	logic [`XLEN-1:0] regs [`NUM_REGS];

	// The register file starts out all zero after reset
	always_ff @(posedge i_clk or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wb.wren && (i_wb.addr != '0)) begin
			regs[i_wb.addr] <= i_wb.data;
		end
	end

	// No write bypass, a same-cycle read sees the old value
	always_comb begin
		o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
		o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];
	end

endmodule

// File: rtl/rv_id_ex_reg.sv
`timescale 1ns/1ps

module rv_id_ex_reg import rv_core_pkg::*; (
	input  logic   i_clk,
	input  logic   reset,
	input  logic   i_flush,
	input  id_ex_t i_stage,
	output id_ex_t o_stage
);

	// A flushed stage is all zero, so insn_vld and every enable drop
	always_ff @(posedge i_clk or negedge reset) begin
		if (!reset) begin
			o_stage <= '0;
		end else if (i_flush) begin
			o_stage <= '0;
		end else begin
			o_stage <= i_stage;
		end
	end

endmodule

// File: rtl/rv_execute.sv
`timescale 1ns/1ps
`include "rv_core_params.svh"

module rv_execute import rv_core_pkg::*; (
	input  id_ex_t  i_stage,
	output ex_res_t o_ex_res
);

	logic [`XLEN-1:0] op_a;
	logic [`XLEN-1:0] op_b;
	logic [4:0]       shamt;
	logic [`XLEN-1:0] alu_result;
	logic             rs_eq;
	logic             rs_lt;
	logic             cond;
	logic [`XLEN-1:0] jalr_sum;
	logic [`XLEN-1:0] target_pc;

	assign op_a  = i_stage.ctrl.opa_sel ? i_stage.pc : i_stage.rs1_data;
	assign op_b  = i_stage.ctrl.opb_sel ? i_stage.imm : i_stage.rs2_data;
	assign shamt = op_b[4:0];

	always_comb begin
		case (i_stage.ctrl.alu_op)
			ALU_ADD:    alu_result = op_a + op_b;
			ALU_SUB:    alu_result = op_a - op_b;
			ALU_SLL:    alu_result = op_a << shamt;
			ALU_SLT:    alu_result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			ALU_SLTU:   alu_result = {{(`XLEN-1){1'b0}}, op_a < op_b};
			ALU_XOR:    alu_result = op_a ^ op_b;
			ALU_SRL:    alu_result = op_a >> shamt;
			ALU_SRA:    alu_result = $unsigned($signed(op_a) >>> shamt);
			ALU_OR:     alu_result = op_a | op_b;
			ALU_AND:    alu_result = op_a & op_b;
			ALU_PASS_B: alu_result = op_b;
			default:    alu_result = '0;
		endcase
	end

	// Branch comparator always looks at the register operands
	assign rs_eq = (i_stage.rs1_data == i_stage.rs2_data);
	assign rs_lt = i_stage.ctrl.br_un ? (i_stage.rs1_data < i_stage.rs2_data)
	                                  : ($signed(i_stage.rs1_data) < $signed(i_stage.rs2_data));

	always_comb begin
		case (i_stage.ctrl.br_sel)
			BR_EQ:            cond = rs_eq;
			BR_NE:            cond = !rs_eq;
			BR_LT:            cond = rs_lt;
			BR_GE:            cond = !rs_lt;
			BR_JAL, BR_JALR:  cond = 1'b1;
			default:          cond = 1'b0;
		endcase
	end

	assign jalr_sum  = i_stage.rs1_data + i_stage.imm;
	assign target_pc = (i_stage.ctrl.br_sel == BR_JALR) ? {jalr_sum[`XLEN-1:1], 1'b0}
	                                                   : i_stage.pc + i_stage.imm;

	always_comb begin
		o_ex_res.valid        = i_stage.ctrl.insn_vld;
		o_ex_res.alu_result   = alu_result;
		o_ex_res.rd_addr      = i_stage.rd_addr;
		o_ex_res.rd_wren      = i_stage.ctrl.rd_wren;
		o_ex_res.wb_sel       = i_stage.ctrl.wb_sel;
		o_ex_res.mem_wren     = i_stage.ctrl.mem_wren;
		o_ex_res.sl_sel       = i_stage.ctrl.sl_sel;
		o_ex_res.store_data   = i_stage.rs2_data;
		o_ex_res.branch_taken = cond && i_stage.ctrl.insn_vld;
		o_ex_res.target_pc    = target_pc;
		o_ex_res.pc           = i_stage.pc;
	end

endmodule

// File: rtl/rv_decode_execute.sv
`timescale 1ns/1ps
`include "rv_core_params.svh"

module rv_decode_execute import rv_core_pkg::*; (
	input  logic             i_clk,
	input  logic             reset,
	input  instr_u           i_instr,
	input  logic [`XLEN-1:0] i_pc,
	input  logic             i_insn_vld,
	input  logic             i_flush,
	input  wb_t              i_wb,
	output ex_res_t          o_ex_res
);

	ctrl_t                  dec_ctrl;
	logic [`XLEN-1:0]       dec_imm;
	logic [`REG_ADDR_W-1:0] rs1_addr;
	logic [`REG_ADDR_W-1:0] rs2_addr;
	logic [`REG_ADDR_W-1:0] rd_addr;
	logic [`XLEN-1:0]       rs1_data;
	logic [`XLEN-1:0]       rs2_data;
	id_ex_t                 id_stage;
	id_ex_t                 ex_stage;

	rv_decoder rv_decoder_i (
		.i_instr    (i_instr),
		.i_insn_vld (i_insn_vld),
		.o_ctrl     (dec_ctrl),
		.o_imm      (dec_imm),
		.o_rs1_addr (rs1_addr),
		.o_rs2_addr (rs2_addr),
		.o_rd_addr  (rd_addr)
	);

	rv_regfile rv_regfile_i (
		.i_clk      (i_clk),
		.reset      (reset),
		.i_wb       (i_wb),
		.i_rs1_addr (rs1_addr),
		.i_rs2_addr (rs2_addr),
		.o_rs1_data (rs1_data),
		.o_rs2_data (rs2_data)
	);

	// Everything the execute stage needs for this instruction
	assign id_stage = '{pc: i_pc, rs1_addr: rs1_addr, rs2_addr: rs2_addr, rd_addr: rd_addr,
	                    ctrl: dec_ctrl, imm: dec_imm, rs1_data: rs1_data, rs2_data: rs2_data};

	rv_id_ex_reg rv_id_ex_reg_i (
		.i_clk   (i_clk),
		.reset   (reset),
		.i_flush (i_flush),
		.i_stage (id_stage),
		.o_stage (ex_stage)
	);

	rv_execute rv_execute_i (
		.i_stage  (ex_stage),
		.o_ex_res (o_ex_res)
	);

endmodule

// File: sim/tb_rv_decode_execute.sv
`timescale 1ns/1ps
`include "rv_core_params.svh"

module tb_rv_decode_execute import rv_core_pkg::*; ();

	logic             i_clk;
	logic             reset;
	instr_u           i_instr;
	logic [`XLEN-1:0] i_pc;
	logic             i_insn_vld;
	logic             i_flush;
	wb_t              i_wb;
	ex_res_t          o_ex_res;

	logic [`XLEN-1:0] ref_regs [`NUM_REGS];
	integer           seed;
	int               cycle;
	int               errors;

	// Results waiting for the compare process with one entry per issued instruction
	ex_res_t exp_q [$];
	ex_res_t mask_q [$];
	string   name_q [$];
	int      due_q [$];
	bit      word_q [$];   // Set when only alu_result is compared

	rv_decode_execute rv_decode_execute_i (
		.i_clk      (i_clk),
		.reset      (reset),
		.i_instr    (i_instr),
		.i_pc       (i_pc),
		.i_insn_vld (i_insn_vld),
		.i_flush    (i_flush),
		.i_wb       (i_wb),
		.o_ex_res   (o_ex_res)
	);

	always #2 i_clk = ~i_clk;

	always @(posedge i_clk) cycle <= cycle + 1;

	function automatic logic [`XLEN-1:0] ref_alu(input logic [2:0] f3, input logic alt,
			input logic [`XLEN-1:0] x, input logic [`XLEN-1:0] y);
		logic [`XLEN-1:0] r;
		case (f3)
			3'b000: r = alt ? x - y : x + y;
			3'b001: r = x << y[4:0];
			3'b010: r = {31'b0, $signed(x) < $signed(y)};
			3'b011: r = {31'b0, x < y};
			3'b100: r = x ^ y;
			3'b101: begin
				if (alt)
					r = $signed(x) >>> y[4:0];   // Arithmetic shift keeps the sign
				else
					r = x >> y[4:0];
			end
			3'b110: r = x | y;
			default: r = x & y;
		endcase
		return r;
	endfunction

	// Expected result of one instruction where the mask marks the fields that carry meaning
	function automatic ex_res_t ref_ex_res(input logic [31:0] w, input logic [`XLEN-1:0] pc,
			input logic vld, output ex_res_t mask);
		ex_res_t          r;
		logic [`XLEN-1:0] a;
		logic [`XLEN-1:0] b;
		logic [`XLEN-1:0] imm_i;
		logic [`XLEN-1:0] imm_s;
		logic [`XLEN-1:0] imm_b;
		logic [`XLEN-1:0] imm_u;
		logic [`XLEN-1:0] imm_j;
		logic [2:0]       f3;
		logic             legal;
		logic             writes_rd;
		a = ref_regs[w[19:15]];
		b = ref_regs[w[24:20]];
		f3 = w[14:12];
		imm_i = {{20{w[31]}}, w[31:20]};
		imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
		imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		imm_u = {w[31:12], 12'b0};
		imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		r = '0;
		mask = '0;
		mask.pc = '1;
		r.pc = pc;
		r.wb_sel = WB_ALU;
		legal = 1'b1;
		writes_rd = 1'b1;
		case (w[6:0])
			7'b0110011: r.alu_result = ref_alu(f3, w[30], a, b);
			7'b0010011: r.alu_result = ref_alu(f3, (f3 == 3'b101) && w[30], a, imm_i);
			7'b0110111: r.alu_result = imm_u;
			7'b0010111: r.alu_result = pc + imm_u;
			7'b0000011, 7'b0100011: begin
				legal = (w[6:0] == 7'b0000011) ? (f3 inside {0, 1, 2, 4, 5}) : (f3 inside {0, 1, 2});
				writes_rd = (w[6:0] == 7'b0000011);
				r.wb_sel = WB_MEM;
				r.mem_wren = !writes_rd;
				r.alu_result = writes_rd ? a + imm_i : a + imm_s;
				r.sl_sel = f3;
				r.store_data = b;
				mask.sl_sel = '1;
				mask.store_data = writes_rd ? '0 : '1;
			end
			7'b1100011: begin
				writes_rd = 1'b0;
				mask.target_pc = '1;
				r.target_pc = pc + imm_b;
				case (f3)
					3'b000: r.branch_taken = (a == b);
					3'b001: r.branch_taken = (a != b);
					3'b100: r.branch_taken = $signed(a) < $signed(b);
					3'b101: r.branch_taken = $signed(a) >= $signed(b);
					3'b110: r.branch_taken = a < b;
					3'b111: r.branch_taken = a >= b;
					default: legal = 1'b0;
				endcase
			end
			7'b1101111, 7'b1100111: begin
				legal = (w[6:0] == 7'b1101111) || (f3 == 3'b000);
				r.wb_sel = WB_PC4;
				r.branch_taken = 1'b1;
				r.target_pc = (w[3]) ? pc + imm_j : (a + imm_i) & ~32'd1;   // Bit 3 tells JAL
				mask.target_pc = '1;
			end
			default: legal = 1'b0;
		endcase
		if (writes_rd && w[6:0] != 7'b0100011) begin
			r.rd_wren = 1'b1;
			r.rd_addr = w[11:7];
			mask.rd_addr = '1;
			mask.wb_sel = wb_sel_e'(2'b11);
			mask.alu_result = (r.wb_sel == WB_PC4) ? '0 : '1;
		end
		if (w[6:0] == 7'b0100011)
			mask.alu_result = '1;
		r.valid = legal && vld;
		if (!r.valid) begin
			r.rd_wren = 1'b0;
			r.mem_wren = 1'b0;
			r.branch_taken = 1'b0;
			mask = '0;
		end
		mask.valid = 1'b1;
		mask.rd_wren = 1'b1;
		mask.mem_wren = 1'b1;
		mask.branch_taken = 1'b1;
		return r;
	endfunction

	task automatic check_ex_res(input string name, input ex_res_t exp, input ex_res_t mask,
			input ex_res_t act);
		if (((exp ^ act) & mask) !== '0) begin
			errors++;
			$display("Fail %s: expected %h actual %h mask %h", name, exp, act, mask);
			$display("TESTS FAILED");
			$fatal(1, "Stopping at the first mismatch");
		end
	endtask

	task automatic check_word(input string name, input logic [`XLEN-1:0] exp,
			input logic [`XLEN-1:0] act);
		if (exp !== act) begin
			errors++;
			$display("Fail %s: expected %h actual %h", name, exp, act);
			$display("TESTS FAILED");
			$fatal(1, "Stopping at the first mismatch");
		end
	endtask

	// Outputs are sampled mid-cycle one edge after the issue
	always @(negedge i_clk) begin
		if (due_q.size() != 0 && due_q[0] == cycle) begin
			if (word_q[0])
				check_word(name_q[0], exp_q[0].alu_result, o_ex_res.alu_result);
			else
				check_ex_res(name_q[0], exp_q[0], mask_q[0], o_ex_res);
			void'(exp_q.pop_front());
			void'(mask_q.pop_front());
			void'(name_q.pop_front());
			void'(due_q.pop_front());
			void'(word_q.pop_front());
		end
	end

	task automatic issue(input string name, input logic [31:0] w, input logic [`XLEN-1:0] pc,
			input logic vld, input logic flush, input bit word_only);
		ex_res_t exp;
		ex_res_t mask;
		@(posedge i_clk);
		#1;
		i_instr = w;
		i_pc = pc;
		i_insn_vld = vld;
		i_flush = flush;
		i_wb = '0;
		exp = ref_ex_res(w, pc, vld, mask);
		if (flush) begin
			exp = '0;   // A flushed stage drives zero on every field
			mask = '1;
		end
		exp_q.push_back(exp);
		mask_q.push_back(mask);
		name_q.push_back(name);
		due_q.push_back(cycle + 1);
		word_q.push_back(word_only);
	endtask

	task automatic write_reg(input logic [`REG_ADDR_W-1:0] addr, input logic [`XLEN-1:0] data);
		@(posedge i_clk);
		#1;
		i_insn_vld = 1'b0;
		i_flush = 1'b0;
		i_wb.wren = 1'b1;
		i_wb.addr = addr;
		i_wb.data = data;
		if (addr != '0)
			ref_regs[addr] = data;   // x0 stays zero
	endtask

	function automatic logic [`XLEN-1:0] rand_pc();
		logic [`XLEN-1:0] pc;
		pc = $random(seed);
		pc[1:0] = 2'b00;
		return pc;
	endfunction

	// Group 0 is ALU, group 1 upper immediates and memory, group 2 control flow
	function automatic logic [31:0] rand_instr(input int group);
		logic [31:0] r;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		logic [11:0] imm;
		logic [1:0]  pick;
		r = $random(seed);
		pick = $random(seed);
		rs2 = r[24:20];
		f3 = r[14:12];
		imm = r[31:20];
		if (group == 0) begin
			if (pick[0])
				return {1'b0, r[30] && (f3 == 3'b000 || f3 == 3'b101), 5'b0, rs2, r[19:7], OPC_OP};
			if (f3 == 3'b001)
				imm = {7'b0, imm[4:0]};
			else if (f3 == 3'b101)
				imm = {1'b0, r[30], 5'b0, imm[4:0]};
			return {imm, r[19:7], OPC_OP_IMM};
		end
		if (group == 1) begin
			case (pick)
				2'd0: return {r[31:7], OPC_LUI};
				2'd1: return {r[31:7], OPC_AUIPC};
				2'd2: return {imm, r[19:15], (f3[1:0] == 2'b11) ? 3'b010 : {f3[2] & !f3[1], f3[1:0]},
					r[11:7], OPC_LOAD};
				default: return {r[31:15], (f3[1:0] == 2'b11) ? 3'b000 : {1'b0, f3[1:0]},
					r[11:7], OPC_STORE};
			endcase
		end
		case (pick)
			2'd0, 2'd1: begin
				if (pick[0])
					rs2 = r[19:15];   // Equal operands now and then
				f3 = (f3[2:1] == 2'b01) ? {2'b10, f3[0]} : f3;
				return {r[31:25], rs2, r[19:15], f3, r[11:7], OPC_BRANCH};
			end
			2'd2: return {r[31:7], OPC_JAL};
			default: return {imm, r[19:15], 3'b000, r[11:7], OPC_JALR};
		endcase
	endfunction

	initial begin
		int waited;
		seed = 32'hd897;
		i_clk = 1'b0;
		reset = 1'b0;
		i_instr = '0;
		i_pc = '0;
		i_insn_vld = 1'b0;
		i_flush = 1'b0;
		i_wb = '0;
		cycle = 0;
		errors = 0;
		for (int i = 0; i < `NUM_REGS; i++)
			ref_regs[i] = '0;
		repeat (8) @(posedge i_clk);
		#1;
		reset = 1'b1;
		@(negedge i_clk);
		check_ex_res("reset_state", '0, '1, o_ex_res);
		for (int i = 0; i < `NUM_REGS; i++)
			issue("reset_regs", {7'b0, i[4:0], i[4:0], 3'b110, 5'd1, OPC_OP}, rand_pc(), 1, 0, 1);
		write_reg(5'd0, 32'h5a5a_a5a5);
		for (int i = 1; i < `NUM_REGS; i++)
			write_reg(i[4:0], $random(seed));
		issue("x0_read", {7'b0, 5'd0, 5'd0, 3'b110, 5'd2, OPC_OP}, rand_pc(), 1, 0, 0);
		for (int n = 0; n < 200; n++)
			issue("alu", rand_instr(0), rand_pc(), 1, 0, 0);
		for (int n = 0; n < 200; n++)
			issue("upper_mem", rand_instr(1), rand_pc(), 1, 0, 0);
		for (int n = 0; n < 200; n++)
			issue("branch_jump", rand_instr(2), rand_pc(), 1, 0, 0);
		issue("flush", rand_instr(0), rand_pc(), 1, 1, 0);
		for (int n = 0; n < 30; n++)
			issue("back_to_back", rand_instr(n % 3), rand_pc(), 1, (n % 7) == 3, 0);
		issue("bad_opcode", {$random(seed)} | 32'h7f, rand_pc(), 1, 0, 0);
		issue("bad_opcode", {$random(seed)} & ~32'h7f, rand_pc(), 1, 0, 0);
		issue("bad_jalr", {17'h12345, 3'b001, 5'd3, OPC_JALR}, rand_pc(), 1, 0, 0);
		issue("bad_branch", {17'h0a5a5, 3'b010, 5'd4, OPC_BRANCH}, rand_pc(), 1, 0, 0);
		issue("bad_load", {17'h0f0f0, 3'b011, 5'd5, OPC_LOAD}, rand_pc(), 1, 0, 0);
		issue("bad_store", {17'h13333, 3'b100, 5'd6, OPC_STORE}, rand_pc(), 1, 0, 0);
		for (int n = 0; n < 12; n++)
			issue("vld_low", rand_instr(n % 3), rand_pc(), 0, 0, 0);
		@(posedge i_clk);
		#1;
		i_insn_vld = 1'b0;
		waited = 0;
		while (due_q.size() != 0 && waited < 100) begin
			@(posedge i_clk);
			waited++;
		end
		if (due_q.size() != 0) begin
			$display("Timeout: %0d results never reached the compare process", due_q.size());
			$display("TESTS FAILED");
			$fatal(1, "Run ended on a timeout");
		end else begin
			if (errors == 0) begin
				$display("TESTS PASSED");
			end else begin
				$display("TESTS FAILED");
			end
			$finish;
		end
	end

endmodule

// File: rv_decode_execute.f
+incdir+rtl
rtl/rv_core_pkg.sv
rtl/rv_decoder.sv
rtl/rv_regfile.sv
rtl/rv_id_ex_reg.sv
rtl/rv_execute.sv
rtl/rv_decode_execute.sv
sim/tb_rv_decode_execute.sv

// File: Bender.yml
package:
  name: rv_decode_execute

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rv_core_pkg.sv
      - rtl/rv_decoder.sv
      - rtl/rv_regfile.sv
      - rtl/rv_id_ex_reg.sv
      - rtl/rv_execute.sv
      - rtl/rv_decode_execute.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - sim/tb_rv_decode_execute.sv
